//--- rtl/ros2_share_defines.svh
`ifndef ROS2_SHARE_DEFINES_SVH
`define ROS2_SHARE_DEFINES_SVH

// ------------------------------------------------------------------------
// byte queue geometry
// ------------------------------------------------------------------------

// width of one queue entry
`define ROS2_BYTE_W 8

// receive path, bytes from the stack to the protocol core
`define ROS2_RX_QUEUE_DEPTH 16

// transmit path, bytes from the protocol core to the stack
`define ROS2_TX_QUEUE_DEPTH 16

`endif

//--- rtl/ros2_share_pkg.sv
package ros2_share_pkg;

  // ------------------------------------------------------------------------
  // app-data record arbitration
  // ------------------------------------------------------------------------

  typedef enum logic [1:0] {
    APP_GRANT_NONE = 2'b00,  // record free
    APP_GRANT_IP   = 2'b01,  // held by the protocol core
    APP_GRANT_CPU  = 2'b10   // held by the cpu
  } app_grant_e;

  // ------------------------------------------------------------------------
  // udp buffer ownership
  // ------------------------------------------------------------------------

  typedef enum logic {
    BUF_OWNER_IP  = 1'b0,
    BUF_OWNER_CPU = 1'b1
  } buf_owner_e;

endpackage

//--- rtl/ros2_share_if.sv
`timescale 1ns/100ps

// request/release/grant set for the shared app-data record
interface app_share_if;

  logic ip_req;     // level
  logic ip_rel;     // one-cycle pulse
  logic cpu_req;    // level
  logic cpu_rel;    // one-cycle pulse
  logic ip_grant;
  logic cpu_grant;

  modport arbiter (
    input  ip_req, ip_rel, cpu_req, cpu_rel,
    output ip_grant, cpu_grant
  );

  modport client (
    output ip_req, ip_rel, cpu_req, cpu_rel,
    input  ip_grant, cpu_grant
  );

endinterface

// release/grant set for one udp buffer, ownership always held by one side
interface buf_share_if;

  logic ip_rel;     // one-cycle pulse
  logic cpu_rel;    // one-cycle pulse
  logic ip_grant;
  logic cpu_grant;

  modport owner (
    input  ip_rel, cpu_rel,
    output ip_grant, cpu_grant
  );

  modport client (
    output ip_rel, cpu_rel,
    input  ip_grant, cpu_grant
  );

endinterface

//--- rtl/app_data_arbiter.sv
`timescale 1ns/100ps

module app_data_arbiter (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_ether_en,
  app_share_if.arbiter     arb
);

  ros2_share_pkg::app_grant_e state_q;

  // ------------------------------------------------------------------------
  // grant state
  // ------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ros2_share_pkg::APP_GRANT_NONE;
    end else begin
      case (state_q)
        ros2_share_pkg::APP_GRANT_NONE: begin
          if (arb.ip_req) begin             // ip wins a tie
            state_q <= ros2_share_pkg::APP_GRANT_IP;
          end else if (arb.cpu_req) begin
            state_q <= ros2_share_pkg::APP_GRANT_CPU;
          end
        end
        ros2_share_pkg::APP_GRANT_IP: begin
          if (arb.ip_rel) begin             // cpu request waits until here
            state_q <= ros2_share_pkg::APP_GRANT_NONE;
          end
        end
        ros2_share_pkg::APP_GRANT_CPU: begin
          if (arb.cpu_rel) begin
            state_q <= ros2_share_pkg::APP_GRANT_NONE;
          end
        end
        default: begin
          state_q <= ros2_share_pkg::APP_GRANT_NONE;  // illegal 2'b11
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // grants, masked while ethernet is off
  // ------------------------------------------------------------------------

  // state keeps running underneath the mask
  assign arb.ip_grant  = i_ether_en & (state_q == ros2_share_pkg::APP_GRANT_IP);
  assign arb.cpu_grant = i_ether_en & (state_q == ros2_share_pkg::APP_GRANT_CPU);

endmodule

//--- rtl/buffer_handover.sv
`timescale 1ns/100ps

module buffer_handover #(
  parameter ros2_share_pkg::buf_owner_e RESET_OWNER = ros2_share_pkg::BUF_OWNER_IP
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_ether_en,
  buf_share_if.owner  bus
);

  ros2_share_pkg::buf_owner_e owner_q;

  // ------------------------------------------------------------------------
  // ownership register
  // ------------------------------------------------------------------------

  // only the current owner can give the buffer away
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= RESET_OWNER;
    end else begin
      case (owner_q)
        ros2_share_pkg::BUF_OWNER_IP: begin
          if (bus.ip_rel) begin
            owner_q <= ros2_share_pkg::BUF_OWNER_CPU;
          end
        end
        ros2_share_pkg::BUF_OWNER_CPU: begin
          if (bus.cpu_rel) begin
            owner_q <= ros2_share_pkg::BUF_OWNER_IP;
          end
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // grants
  // ------------------------------------------------------------------------

  assign bus.ip_grant  = i_ether_en & (owner_q == ros2_share_pkg::BUF_OWNER_IP);
  assign bus.cpu_grant = i_ether_en & (owner_q == ros2_share_pkg::BUF_OWNER_CPU);

endmodule

//--- rtl/byte_queue.sv
`timescale 1ns/100ps

`include "ros2_share_defines.svh"

module byte_queue #(
  parameter int DEPTH = 16                  // power of two
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    i_wr_en,
  input  logic [`ROS2_BYTE_W-1:0] i_din,

  input  logic                    i_rd_en,
  output logic [`ROS2_BYTE_W-1:0] o_dout,

  output logic                    o_full,
  output logic                    o_empty
);

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] CNT_FULL = (AW + 1)'(DEPTH);

  logic [`ROS2_BYTE_W-1:0] mem [DEPTH];
  logic [AW-1:0]           wr_ptr_q;
  logic [AW-1:0]           rd_ptr_q;
  logic [AW:0]             count_q;
  logic                    wr_ok;
  logic                    rd_ok;

  // back-pressure drops the strobe, nothing else moves
  assign wr_ok = i_wr_en & ~o_full;
  assign rd_ok = i_rd_en & ~o_empty;

  // ------------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr_q] <= i_din;
    end
  end

  assign o_dout = mem[rd_ptr_q];            // show-ahead

  // ------------------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;        // wraps at DEPTH
      end
      if (rd_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;        // idle or push and pop together
      endcase
    end
  end

  assign o_full  = (count_q == CNT_FULL);
  assign o_empty = (count_q == '0);

endmodule

//--- rtl/ros2_ether_share.sv
`timescale 1ns/100ps

`include "ros2_share_defines.svh"

module ros2_ether_share (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_ether_en,

  // app-data record
  input  logic                    i_ip_app_req,
  input  logic                    i_ip_app_rel,
  input  logic                    i_cpu_app_req,
  input  logic                    i_cpu_app_rel,
  output logic                    o_ip_app_grant,
  output logic                    o_cpu_app_grant,

  // udp receive buffer
  input  logic                    i_ip_rxbuf_rel,
  input  logic                    i_cpu_rxbuf_rel,
  output logic                    o_ip_rxbuf_grant,
  output logic                    o_cpu_rxbuf_grant,

  // udp transmit buffer
  input  logic                    i_ip_txbuf_rel,
  input  logic                    i_cpu_txbuf_rel,
  output logic                    o_ip_txbuf_grant,
  output logic                    o_cpu_txbuf_grant,

  // receive byte queue
  input  logic                    i_rx_wr_en,
  input  logic [`ROS2_BYTE_W-1:0] i_rx_din,
  input  logic                    i_rx_rd_en,
  output logic [`ROS2_BYTE_W-1:0] o_rx_dout,
  output logic                    o_rx_full,
  output logic                    o_rx_empty,

  // transmit byte queue
  input  logic                    i_tx_wr_en,
  input  logic [`ROS2_BYTE_W-1:0] i_tx_din,
  input  logic                    i_tx_rd_en,
  output logic [`ROS2_BYTE_W-1:0] o_tx_dout,
  output logic                    o_tx_full,
  output logic                    o_tx_empty
);

  app_share_if app_bus ();
  buf_share_if rxbuf_bus ();
  buf_share_if txbuf_bus ();

  // ------------------------------------------------------------------------
  // app-data arbiter
  // ------------------------------------------------------------------------

  assign app_bus.ip_req  = i_ip_app_req;
  assign app_bus.ip_rel  = i_ip_app_rel;
  assign app_bus.cpu_req = i_cpu_app_req;
  assign app_bus.cpu_rel = i_cpu_app_rel;
  assign o_ip_app_grant  = app_bus.ip_grant;
  assign o_cpu_app_grant = app_bus.cpu_grant;

  app_data_arbiter u_app_data_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ether_en (i_ether_en),
    .arb        (app_bus.arbiter)
  );

  // ------------------------------------------------------------------------
  // udp buffer handovers
  // ------------------------------------------------------------------------

  assign rxbuf_bus.ip_rel   = i_ip_rxbuf_rel;
  assign rxbuf_bus.cpu_rel  = i_cpu_rxbuf_rel;
  assign o_ip_rxbuf_grant   = rxbuf_bus.ip_grant;
  assign o_cpu_rxbuf_grant  = rxbuf_bus.cpu_grant;

  assign txbuf_bus.ip_rel   = i_ip_txbuf_rel;
  assign txbuf_bus.cpu_rel  = i_cpu_txbuf_rel;
  assign o_ip_txbuf_grant   = txbuf_bus.ip_grant;
  assign o_cpu_txbuf_grant  = txbuf_bus.cpu_grant;

  // core fills the rx buffer first
  buffer_handover #(
    .RESET_OWNER (ros2_share_pkg::BUF_OWNER_IP)
  ) u_rxbuf_handover (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ether_en (i_ether_en),
    .bus        (rxbuf_bus.owner)
  );

  // cpu fills the tx buffer first
  buffer_handover #(
    .RESET_OWNER (ros2_share_pkg::BUF_OWNER_CPU)
  ) u_txbuf_handover (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ether_en (i_ether_en),
    .bus        (txbuf_bus.owner)
  );

  // ------------------------------------------------------------------------
  // byte queues
  // ------------------------------------------------------------------------

  byte_queue #(
    .DEPTH (`ROS2_RX_QUEUE_DEPTH)
  ) u_rx_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr_en (i_rx_wr_en),
    .i_din   (i_rx_din),
    .i_rd_en (i_rx_rd_en),
    .o_dout  (o_rx_dout),
    .o_full  (o_rx_full),
    .o_empty (o_rx_empty)
  );

  byte_queue #(
    .DEPTH (`ROS2_TX_QUEUE_DEPTH)
  ) u_tx_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr_en (i_tx_wr_en),
    .i_din   (i_tx_din),
    .i_rd_en (i_tx_rd_en),
    .o_dout  (o_tx_dout),
    .o_full  (o_tx_full),
    .o_empty (o_tx_empty)
  );

endmodule

//--- testbench/ros2_share_sva.sv
`timescale 1ns/100ps

module ros2_share_sva (
  input logic clk,
  input logic rst_n,
  input logic i_ether_en,
  input logic i_ip_app_rel,
  input logic i_ip_app_grant,
  input logic i_cpu_app_grant,
  input logic i_ip_rxbuf_grant,
  input logic i_cpu_rxbuf_grant,
  input logic i_ip_txbuf_grant,
  input logic i_cpu_txbuf_grant,
  input logic i_rx_full,
  input logic i_rx_empty,
  input logic i_tx_full,
  input logic i_tx_empty
);

  // --------------------------------------------------------------------------
  // grant exclusion
  // --------------------------------------------------------------------------

  a_app_one_holder: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_ip_app_grant && i_cpu_app_grant)) else $error("app-data granted to both sides");

  a_rxbuf_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_ip_rxbuf_grant && i_cpu_rxbuf_grant)) else $error("rx buffer granted to both sides");

  a_txbuf_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_ip_txbuf_grant && i_cpu_txbuf_grant)) else $error("tx buffer granted to both sides");

  // ip only loses the record by releasing it
  a_ip_app_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ($fell(i_ip_app_grant) && i_ether_en) |-> $past(i_ip_app_rel))
    else $error("ip app grant dropped without a release");

  // --------------------------------------------------------------------------
  // queue flags
  // --------------------------------------------------------------------------

  a_rx_flags: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_rx_full && i_rx_empty)) else $error("rx queue full and empty together");

  a_tx_flags: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_tx_full && i_tx_empty)) else $error("tx queue full and empty together");

endmodule

bind ros2_ether_share ros2_share_sva u_share_sva (
  .clk               (clk),
  .rst_n             (rst_n),
  .i_ether_en        (i_ether_en),
  .i_ip_app_rel      (i_ip_app_rel),
  .i_ip_app_grant    (o_ip_app_grant),
  .i_cpu_app_grant   (o_cpu_app_grant),
  .i_ip_rxbuf_grant  (o_ip_rxbuf_grant),
  .i_cpu_rxbuf_grant (o_cpu_rxbuf_grant),
  .i_ip_txbuf_grant  (o_ip_txbuf_grant),
  .i_cpu_txbuf_grant (o_cpu_txbuf_grant),
  .i_rx_full         (o_rx_full),
  .i_rx_empty        (o_rx_empty),
  .i_tx_full         (o_tx_full),
  .i_tx_empty        (o_tx_empty)
);

//--- testbench/tb_ros2_ether_share.sv
`timescale 1ns/100ps

`include "ros2_share_defines.svh"

module tb_ros2_ether_share;

  localparam int RX_DEPTH = `ROS2_RX_QUEUE_DEPTH;
  localparam int TX_DEPTH = `ROS2_TX_QUEUE_DEPTH;
  localparam int BW       = `ROS2_BYTE_W;

  logic          clk;
  logic          rst_n;
  logic          i_ether_en;
  logic          i_ip_app_req, i_ip_app_rel, i_cpu_app_req, i_cpu_app_rel;
  logic          o_ip_app_grant, o_cpu_app_grant;
  logic          i_ip_rxbuf_rel, i_cpu_rxbuf_rel, o_ip_rxbuf_grant, o_cpu_rxbuf_grant;
  logic          i_ip_txbuf_rel, i_cpu_txbuf_rel, o_ip_txbuf_grant, o_cpu_txbuf_grant;
  logic          i_rx_wr_en, i_rx_rd_en, o_rx_full, o_rx_empty;
  logic          i_tx_wr_en, i_tx_rd_en, o_tx_full, o_tx_empty;
  logic [BW-1:0] i_rx_din, o_rx_dout, i_tx_din, o_tx_dout;

  // reference models, advanced once per rising edge
  ros2_share_pkg::app_grant_e app_model;
  ros2_share_pkg::buf_owner_e rxbuf_model;
  ros2_share_pkg::buf_owner_e txbuf_model;
  logic [BW-1:0]              rx_model[$];
  logic [BW-1:0]              tx_model[$];

  string cur_test;
  int    errors;
  int    test_errs;
  int    tests_run;
  int    tests_failed;
  bit    aborted;

  ros2_ether_share UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // models and checks
  // --------------------------------------------------------------------------

  task update_models();
    logic rx_wr, rx_rd, tx_wr, tx_rd;
    case (app_model)
      ros2_share_pkg::APP_GRANT_NONE: begin
        if (i_ip_app_req) app_model = ros2_share_pkg::APP_GRANT_IP;   // ip first on a tie
        else if (i_cpu_app_req) app_model = ros2_share_pkg::APP_GRANT_CPU;
      end
      ros2_share_pkg::APP_GRANT_IP: if (i_ip_app_rel) app_model = ros2_share_pkg::APP_GRANT_NONE;
      default: if (i_cpu_app_rel) app_model = ros2_share_pkg::APP_GRANT_NONE;
    endcase
    if (rxbuf_model == ros2_share_pkg::BUF_OWNER_IP && i_ip_rxbuf_rel)
      rxbuf_model = ros2_share_pkg::BUF_OWNER_CPU;
    else if (rxbuf_model == ros2_share_pkg::BUF_OWNER_CPU && i_cpu_rxbuf_rel)
      rxbuf_model = ros2_share_pkg::BUF_OWNER_IP;
    if (txbuf_model == ros2_share_pkg::BUF_OWNER_IP && i_ip_txbuf_rel)
      txbuf_model = ros2_share_pkg::BUF_OWNER_CPU;
    else if (txbuf_model == ros2_share_pkg::BUF_OWNER_CPU && i_cpu_txbuf_rel)
      txbuf_model = ros2_share_pkg::BUF_OWNER_IP;
    rx_wr = i_rx_wr_en && (rx_model.size() < RX_DEPTH);   // dropped when full
    rx_rd = i_rx_rd_en && (rx_model.size() > 0);
    tx_wr = i_tx_wr_en && (tx_model.size() < TX_DEPTH);
    tx_rd = i_tx_rd_en && (tx_model.size() > 0);
    if (rx_rd) void'(rx_model.pop_front());
    if (rx_wr) rx_model.push_back(i_rx_din);
    if (tx_rd) void'(tx_model.pop_front());
    if (tx_wr) tx_model.push_back(i_tx_din);
  endtask

  task check_val(input string sig, input logic [BW-1:0] exp, input logic [BW-1:0] act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %0h actual %0h at %0t", cur_test, sig, exp, act, $time);
      errors++;
      test_errs++;
    end
  endtask

  task check_outputs();
    check_val("o_ip_app_grant", i_ether_en && app_model == ros2_share_pkg::APP_GRANT_IP,
              o_ip_app_grant);
    check_val("o_cpu_app_grant", i_ether_en && app_model == ros2_share_pkg::APP_GRANT_CPU,
              o_cpu_app_grant);
    check_val("o_ip_rxbuf_grant", i_ether_en && rxbuf_model == ros2_share_pkg::BUF_OWNER_IP,
              o_ip_rxbuf_grant);
    check_val("o_cpu_rxbuf_grant", i_ether_en && rxbuf_model == ros2_share_pkg::BUF_OWNER_CPU,
              o_cpu_rxbuf_grant);
    check_val("o_ip_txbuf_grant", i_ether_en && txbuf_model == ros2_share_pkg::BUF_OWNER_IP,
              o_ip_txbuf_grant);
    check_val("o_cpu_txbuf_grant", i_ether_en && txbuf_model == ros2_share_pkg::BUF_OWNER_CPU,
              o_cpu_txbuf_grant);
    check_val("o_rx_full", rx_model.size() == RX_DEPTH, o_rx_full);
    check_val("o_rx_empty", rx_model.size() == 0, o_rx_empty);
    check_val("o_tx_full", tx_model.size() == TX_DEPTH, o_tx_full);
    check_val("o_tx_empty", tx_model.size() == 0, o_tx_empty);
    if (rx_model.size() > 0) check_val("o_rx_dout", rx_model[0], o_rx_dout);
    if (tx_model.size() > 0) check_val("o_tx_dout", tx_model[0], o_tx_dout);
  endtask

  // models follow the rising edge and outputs are checked at the falling edge
  task step();
    @(posedge clk);
    update_models();
    @(negedge clk);
    check_outputs();
  endtask

  task finish_test(input int cycles);
    $display("%-18s %4d cycles, %0d errors", cur_test, cycles, test_errs);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    test_errs = 0;
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  task idle_inputs();
    {i_ip_app_req, i_ip_app_rel, i_cpu_app_req, i_cpu_app_rel} = '0;
    {i_ip_rxbuf_rel, i_cpu_rxbuf_rel, i_ip_txbuf_rel, i_cpu_txbuf_rel} = '0;
    {i_rx_wr_en, i_rx_rd_en, i_tx_wr_en, i_tx_rd_en} = '0;
    i_rx_din = '0;
    i_tx_din = '0;
  endtask

  task drive_app_random();
    i_ip_app_req  = ($urandom % 3) == 0;
    i_cpu_app_req = ($urandom % 2) == 0;
    i_ip_app_rel  = !i_ip_app_rel && (($urandom % 4) == 0);     // never two cycles in a row
    i_cpu_app_rel = !i_cpu_app_rel && (($urandom % 4) == 0);
  endtask

  task drive_buf_random();
    i_ip_rxbuf_rel  = !i_ip_rxbuf_rel && (($urandom % 3) == 0);
    i_cpu_rxbuf_rel = !i_cpu_rxbuf_rel && (($urandom % 3) == 0);
    i_ip_txbuf_rel  = !i_ip_txbuf_rel && (($urandom % 3) == 0);
    i_cpu_txbuf_rel = !i_cpu_txbuf_rel && (($urandom % 3) == 0);
  endtask

  task drive_queue_random(input int wr_pct);
    i_rx_wr_en = ($urandom % 100) < wr_pct;
    i_rx_rd_en = ($urandom % 100) >= wr_pct;
    i_rx_din   = BW'($urandom);
    i_tx_wr_en = ($urandom % 100) < wr_pct;
    i_tx_rd_en = ($urandom % 100) >= wr_pct;
    i_tx_din   = BW'($urandom);
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------

  task run_random_grants(input string name, input bit use_app, input bit use_buf);
    cur_test = name;
    idle_inputs();
    for (int i = 0; i < 400; i++) begin
      if (use_app) drive_app_random();
      if (use_buf) drive_buf_random();
      step();
    end
    finish_test(400);
  endtask

  task run_enable_gating();
    int stretch;
    cur_test = "enable_gating";
    stretch  = 3;
    for (int i = 0; i < 400; i++) begin
      if (stretch == 0) begin
        i_ether_en = !i_ether_en;
        stretch    = 1 + ($urandom % 12);
      end
      stretch--;
      drive_app_random();
      drive_buf_random();
      step();
    end
    i_ether_en = 1'b1;
    idle_inputs();
    step();                                 // models must line up again
    finish_test(401);
  endtask

  task run_byte_queues();
    cur_test = "byte_queues";
    idle_inputs();
    for (int i = 0; i < 600; i++) begin
      case ((i / 75) % 3)
        0:       drive_queue_random(85);    // filling run
        1:       drive_queue_random(15);    // draining run
        default: drive_queue_random(50);
      endcase
      step();
    end
    finish_test(600);
  endtask

  task run_fill_drain();
    int n;
    cur_test = "queue_fill_drain";
    idle_inputs();
    n = 0;
    while (!(o_rx_full && o_tx_full) && !aborted) begin
      if (n >= 4 * (RX_DEPTH + TX_DEPTH)) begin
        $display("queues never reported full while being filled");
        aborted = 1'b1;
        errors++;
        test_errs++;
      end else begin
        drive_queue_random(100);
        step();
        n++;
      end
    end
    for (int i = 0; i < 3; i++) begin       // writes against a full queue
      drive_queue_random(100);
      step();
      n++;
    end
    while (!(o_rx_empty && o_tx_empty) && !aborted) begin
      if (n >= 8 * (RX_DEPTH + TX_DEPTH)) begin
        $display("queues never reported empty while being drained");
        aborted = 1'b1;
        errors++;
        test_errs++;
      end else begin
        drive_queue_random(0);
        step();
        n++;
      end
    end
    drive_queue_random(0);                  // read against an empty queue
    step();
    idle_inputs();
    finish_test(n + 1);
  endtask

  initial begin
    int n;
    void'($urandom(32'h3d3f_6e79));
    rst_n      = 1'b0;
    i_ether_en = 1'b1;
    idle_inputs();
    errors       = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    app_model    = ros2_share_pkg::APP_GRANT_NONE;
    rxbuf_model  = ros2_share_pkg::BUF_OWNER_IP;
    txbuf_model  = ros2_share_pkg::BUF_OWNER_CPU;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    n = 0;
    while (!(o_rx_empty && o_tx_empty) && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (n >= 20) begin
      $display("queues did not come out of reset empty");
      aborted = 1'b1;
      errors++;
      test_errs++;
    end

    cur_test = "reset_state";
    check_outputs();
    finish_test(0);
    if (!aborted) run_random_grants("app_arbitration", 1'b1, 1'b0);
    if (!aborted) run_random_grants("buffer_handover", 1'b0, 1'b1);
    if (!aborted) run_enable_gating();
    if (!aborted) run_byte_queues();
    if (!aborted) run_fill_drain();

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+rtl
rtl/ros2_share_pkg.sv
rtl/ros2_share_if.sv
rtl/app_data_arbiter.sv
rtl/buffer_handover.sv
rtl/byte_queue.sv
rtl/ros2_ether_share.sv
testbench/ros2_share_sva.sv
testbench/tb_ros2_ether_share.sv

//--- Bender.yml
package:
  name: ros2_ether_share

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ros2_share_pkg.sv
      - rtl/ros2_share_if.sv
      - rtl/app_data_arbiter.sv
      - rtl/buffer_handover.sv
      - rtl/byte_queue.sv
      - rtl/ros2_ether_share.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/ros2_share_sva.sv
      - testbench/tb_ros2_ether_share.sv
